//--- rtl/fetch_pkg.sv
/*
 * Fetch front end shared definitions.
 * Address type, request and redirect bundles, predictor and queue sizing.
 */

`default_nettype none

package fetch_pkg;

    // instruction address
    typedef logic [31:0] pc_t;

    localparam pc_t START_PC = 32'h8000_0000;  // reset vector
    localparam pc_t INSTR_BYTES = 32'd4;        // no compressed instructions

    // branch history table, direct mapped
    localparam int BHT_ENTRIES = 16;
    localparam int BHT_IDX_W = $clog2(BHT_ENTRIES);
    localparam int BHT_IDX_LSB = 2;                        // word aligned pc
    localparam int BHT_TAG_LSB = BHT_IDX_LSB + BHT_IDX_W;  // pc[31:6]
    localparam int BHT_TAG_W = 32 - BHT_TAG_LSB;

    // fetch queue sizing
    localparam int FQ_DEPTH = 4;
    localparam int FQ_PTR_W = $clog2(FQ_DEPTH);
    localparam int FQ_CNT_W = $clog2(FQ_DEPTH + 1);

    // 2-bit saturating counter, msb set means predict taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t CTR_STRONG_NT = 2'd0;
    localparam ctr_t CTR_WEAK_T = 2'd2;
    localparam ctr_t CTR_STRONG_T = 2'd3;

    typedef struct packed {
        pc_t  pc;
        logic pred_taken;  // next pc came from the target store
    } fetch_req_t;

    typedef struct packed {
        logic valid;
        pc_t  pc;
    } redirect_t;

    // resolved branch coming back from ex
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
        pc_t  target;
    } bp_update_t;

endpackage

`default_nettype wire

//--- rtl/pc_gen.sv
/*
 * Program counter generator.
 * Picks the next fetch address (ex redirect, id redirect, stall, prediction)
 * and hands one request per cycle to the fetch queue.
 */

`timescale 1ns/1ps
`default_nettype none

module pc_gen (
    input  logic                   clk,
    input  logic                   arst_n,
    input  fetch_pkg::redirect_t   ex_redirect,
    input  fetch_pkg::redirect_t   id_redirect,
    input  logic                   stall,
    input  logic                   pred_taken,
    input  fetch_pkg::pc_t         pred_target,
    output fetch_pkg::pc_t         lookup_pc,
    output logic                   push_valid,
    output fetch_pkg::fetch_req_t  push_req,
    input  logic                   push_ready,
    output logic                   flush
);
    import fetch_pkg::*;

    pc_t  pc_q;
    pc_t  pc_d;
    pc_t  seq_pc;
    pc_t  pred_pc;
    logic active_q;   // first cycle after reset release is idle
    logic push_fire;

    // any redirect kills the request in flight and what is queued
    assign flush = ex_redirect.valid | id_redirect.valid;

    assign push_valid = active_q & ~stall & ~flush;
    assign push_fire = push_valid & push_ready;

    assign lookup_pc = pc_q;
    assign seq_pc = pc_q + INSTR_BYTES;
    assign pred_pc = pred_taken ? pred_target : seq_pc;

    always_comb begin
        push_req.pc = pc_q;
        push_req.pred_taken = pred_taken;
    end

    // ex is older than id, so it wins
    always_comb begin
        if (ex_redirect.valid) begin
            pc_d = ex_redirect.pc;
        end else if (id_redirect.valid) begin
            pc_d = id_redirect.pc;
        end else if (push_fire) begin
            pc_d = pred_pc;
        end else begin
            pc_d = pc_q;  // stall or queue full
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_q <= START_PC;
            active_q <= 1'b0;
        end else begin
            pc_q <= pc_d;
            active_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/branch_predictor.sv
/*
 * Branch predictor.
 * Direct-mapped table of 2-bit counters with tags and targets.
 * Combinational lookup, update from resolved branches in ex.
 */

`timescale 1ns/1ps
`default_nettype none

module branch_predictor (
    input  logic                   clk,
    input  logic                   arst_n,
    input  fetch_pkg::pc_t         lookup_pc,
    output logic                   pred_taken,
    output fetch_pkg::pc_t         pred_target,
    input  fetch_pkg::bp_update_t  bp_update
);
    import fetch_pkg::*;

    logic [BHT_ENTRIES-1:0] valid_q;
    logic [BHT_TAG_W-1:0]   tag_q    [BHT_ENTRIES];
    pc_t                    target_q [BHT_ENTRIES];
    ctr_t                   ctr_q    [BHT_ENTRIES];

    logic [BHT_IDX_W-1:0] lk_idx;
    logic [BHT_TAG_W-1:0] lk_tag;
    logic                 lk_hit;
    logic [BHT_IDX_W-1:0] up_idx;
    logic [BHT_TAG_W-1:0] up_tag;
    logic                 up_hit;
    logic                 up_alloc;

    // one step toward the outcome, sticks at both ends
    function automatic ctr_t ctr_step(input ctr_t ctr, input logic taken);
        ctr_t res;
        res = ctr;
        if (taken && ctr != CTR_STRONG_T) begin
            res = ctr + 2'd1;
        end else if (!taken && ctr != CTR_STRONG_NT) begin
            res = ctr - 2'd1;
        end
        return res;
    endfunction

    assign lk_idx = lookup_pc[BHT_TAG_LSB-1:BHT_IDX_LSB];
    assign lk_tag = lookup_pc[31:BHT_TAG_LSB];
    assign lk_hit = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);

    assign pred_taken = lk_hit && ctr_q[lk_idx][1];
    assign pred_target = lk_hit ? target_q[lk_idx] : '0;

    assign up_idx = bp_update.pc[BHT_TAG_LSB-1:BHT_IDX_LSB];
    assign up_tag = bp_update.pc[31:BHT_TAG_LSB];
    assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

    // only a taken branch earns a row, not-taken misses are ignored
    assign up_alloc = bp_update.valid && bp_update.taken && !up_hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else if (up_alloc) begin
            valid_q[up_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (bp_update.valid && up_hit) begin
            ctr_q[up_idx] <= ctr_step(ctr_q[up_idx], bp_update.taken);
            if (bp_update.taken) begin
                target_q[up_idx] <= bp_update.target;  // indirect may move
            end
        end else if (up_alloc) begin
            tag_q[up_idx] <= up_tag;                 // evicts old owner
            target_q[up_idx] <= bp_update.target;
            ctr_q[up_idx] <= CTR_WEAK_T;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_queue.sv
/*
 * Fetch request queue.
 * Circular buffer between pc generation and the instruction memory side,
 * emptied by a redirect flush.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_queue (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flush,
    input  logic                   push_valid,
    input  fetch_pkg::fetch_req_t  push_req,
    output logic                   push_ready,
    output logic                   pop_valid,
    output fetch_pkg::fetch_req_t  pop_req,
    input  logic                   pop_ready
);
    import fetch_pkg::*;

    fetch_req_t          mem_q [FQ_DEPTH];
    logic [FQ_PTR_W-1:0] wr_ptr_q;
    logic [FQ_PTR_W-1:0] rd_ptr_q;
    logic [FQ_CNT_W-1:0] count_q;
    logic                push_fire;
    logic                pop_fire;

    assign push_ready = (count_q != FQ_CNT_W'(FQ_DEPTH));  // back-pressure
    assign pop_valid = (count_q != '0) && !flush;          // stale entries never leave
    assign pop_req = mem_q[rd_ptr_q];

    assign push_fire = push_valid && push_ready && !flush;
    assign pop_fire = pop_valid && pop_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else if (flush) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;  // wraps, depth is a power of two
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({push_fire, pop_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;  // none, or both at once
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push_fire) begin
            mem_q[wr_ptr_q] <= push_req;
        end
    end

endmodule

`default_nettype wire

//--- rtl/fetch_top.sv
/*
 * Instruction fetch front end.
 * pc generator, branch predictor and fetch queue.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  fetch_pkg::redirect_t   ex_redirect,
    input  fetch_pkg::redirect_t   id_redirect,
    input  fetch_pkg::bp_update_t  bp_update,
    input  logic                   stall,
    output logic                   fetch_valid,
    output fetch_pkg::fetch_req_t  fetch_req,
    input  logic                   fetch_ready
);
    import fetch_pkg::*;

    pc_t        lookup_pc;
    logic       pred_taken;
    pc_t        pred_target;
    logic       push_valid;
    fetch_req_t push_req;
    logic       push_ready;
    logic       flush;

    pc_gen i_pc_gen (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_redirect (ex_redirect),
        .id_redirect (id_redirect),
        .stall       (stall),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .lookup_pc   (lookup_pc),
        .push_valid  (push_valid),
        .push_req    (push_req),
        .push_ready  (push_ready),
        .flush       (flush)
    );

    branch_predictor i_branch_predictor (
        .clk         (clk),
        .arst_n      (arst_n),
        .lookup_pc   (lookup_pc),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .bp_update   (bp_update)
    );

    // imem side pops straight from the queue
    fetch_queue i_fetch_queue (
        .clk        (clk),
        .arst_n     (arst_n),
        .flush      (flush),
        .push_valid (push_valid),
        .push_req   (push_req),
        .push_ready (push_ready),
        .pop_valid  (fetch_valid),
        .pop_req    (fetch_req),
        .pop_ready  (fetch_ready)
    );

endmodule

`default_nettype wire

//--- verification/fetch_chk.sv
/*
 * Fetch queue checker.
 * Output handshake stability, full back-pressure and reset state.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_chk (
    input logic                             clk,
    input logic                             arst_n,
    input logic                             flush,
    input logic                             pop_valid,
    input fetch_pkg::fetch_req_t            pop_req,
    input logic                             pop_ready,
    input logic [fetch_pkg::FQ_CNT_W-1:0]   count_q
);
    import fetch_pkg::*;

    int err_cnt = 0;  // failed assertions so far, read by the testbench

    // a waiting request stays put unless a redirect drops it
    assert property (@(posedge clk) disable iff (!arst_n)
        (pop_valid && !pop_ready) |=> (flush || (pop_valid && $stable(pop_req))))
        else begin
            $error("pop request changed before it was accepted");
            err_cnt++;
        end

    // nothing gets in while full, so a full queue without a pop stays full
    assert property (@(posedge clk) disable iff (!arst_n)
        (count_q == FQ_CNT_W'(FQ_DEPTH) && !(pop_valid && pop_ready) && !flush)
        |=> (count_q == FQ_CNT_W'(FQ_DEPTH)))
        else begin
            $error("full queue changed occupancy without a pop");
            err_cnt++;
        end

    assert property (@(posedge clk) !arst_n |-> !pop_valid)
        else begin
            $error("pop_valid high during reset");
            err_cnt++;
        end

endmodule

bind fetch_queue fetch_chk i_fetch_chk (
    .clk        (clk),
    .arst_n     (arst_n),
    .flush      (flush),
    .pop_valid  (pop_valid),
    .pop_req    (pop_req),
    .pop_ready  (pop_ready),
    .count_q    (count_q)
);

`default_nettype wire

//--- verification/fetch_tb.sv
/*
 * Testbench for the fetch front end.
 * Drives redirects, predictor updates, stall and back-pressure, and checks
 * every accepted fetch request against a model of the address stream.
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_tb;
    import fetch_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYC = 16;
    localparam int SEQ_CYC = 60;
    localparam int BP_CYC = 500;
    localparam int EX_CYC = 80;
    localparam int PRI_CYC = 120;
    localparam int PRED_STEPS = 9;
    localparam int PRED_CYC = PRED_STEPS * 60;
    localparam int TOTAL_CYC = RESET_CYC + SEQ_CYC + BP_CYC + EX_CYC + PRI_CYC + PRED_CYC;
    localparam int WATCHDOG_NS = TOTAL_CYC * CLK_PERIOD + 400;

    localparam pc_t BRANCH_PC = 32'h8000_6104;
    localparam pc_t TARGET_PC = 32'h8000_7000;

    logic         clk;
    logic         arst_n;
    redirect_t    ex_redirect;
    redirect_t    id_redirect;
    bp_update_t   bp_update;
    logic         stall;
    logic         fetch_valid;
    fetch_req_t   fetch_req;
    logic         fetch_ready;

    // stimulus modes
    logic         rand_ready;
    logic         rand_stall;
    logic         ready_level;
    integer       seed;

    // reference state
    pc_t          exp_pc;
    int           accept_cnt;
    string        cur_test;
    logic [BHT_ENTRIES-1:0] model_valid;
    logic [25:0]  model_tag [BHT_ENTRIES];
    pc_t          model_target [BHT_ENTRIES];
    logic [1:0]   model_ctr [BHT_ENTRIES];

    bit           outcome_seq [PRED_STEPS] = '{1, 0, 0, 0, 1, 1, 1, 1, 0};

    fetch_top i_dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .ex_redirect (ex_redirect),
        .id_redirect (id_redirect),
        .bp_update   (bp_update),
        .stall       (stall),
        .fetch_valid (fetch_valid),
        .fetch_req   (fetch_req),
        .fetch_ready (fetch_ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic check_value(input string what, input pc_t exp, input pc_t act);
        if (exp !== act) begin
            $display("[ERROR] %s: %s expected 0x%08h, actual 0x%08h", cur_test, what, exp, act);
            stop_on_failure("request stream differs from the model");
        end
    endtask

    // lookup in the model table, taken only on a tag hit with the counter msb set
    function automatic logic predict_taken(input pc_t pc);
        logic [3:0] idx;
        idx = pc[5:2];
        return model_valid[idx] && (model_tag[idx] == pc[31:6]) && model_ctr[idx][1];
    endfunction

    function automatic pc_t next_pc(input pc_t pc);
        if (predict_taken(pc)) begin
            return model_target[pc[5:2]];
        end
        return pc + 32'd4;
    endfunction

    task automatic train_model(input pc_t pc, input logic taken, input pc_t target);
        logic [3:0] idx;
        idx = pc[5:2];
        if (model_valid[idx] && model_tag[idx] == pc[31:6]) begin
            if (taken) begin
                model_ctr[idx] = (model_ctr[idx] == 2'd3) ? 2'd3 : model_ctr[idx] + 2'd1;
                model_target[idx] = target;
            end else begin
                model_ctr[idx] = (model_ctr[idx] == 2'd0) ? 2'd0 : model_ctr[idx] - 2'd1;
            end
        end else if (taken) begin
            model_valid[idx] = 1'b1;  // allocate weakly taken
            model_tag[idx] = pc[31:6];
            model_target[idx] = target;
            model_ctr[idx] = 2'd2;
        end
    endtask

    // next drive point, pulses drop and random inputs change here
    task automatic step_cycle();
        int r;
        @(posedge clk);
        #1;
        ex_redirect = '0;
        id_redirect = '0;
        bp_update = '0;
        r = $random(seed);
        fetch_ready = rand_ready ? (r[1:0] != 2'b00) : ready_level;
        stall = rand_stall ? (r[5:4] == 2'b00) : 1'b0;
    endtask

    task automatic wait_accepts(input int n, input int limit);
        int target;
        int cycles;
        target = accept_cnt + n;
        cycles = 0;
        while (accept_cnt < target) begin
            if (cycles >= limit) begin
                stop_on_failure($sformatf("%s: only %0d of %0d requests arrived in %0d cycles",
                                          cur_test, n - (target - accept_cnt), n, limit));
            end
            step_cycle();
            cycles++;
        end
    endtask

    task automatic send_redirect(input logic ex_v, input pc_t ex_pc,
                                 input logic id_v, input pc_t id_pc);
        step_cycle();
        ex_redirect.valid = ex_v;
        ex_redirect.pc = ex_pc;
        id_redirect.valid = id_v;
        id_redirect.pc = id_pc;
        exp_pc = ex_v ? ex_pc : id_pc;  // ex is older and wins
    endtask

    // resolved branch from ex, restarting fetch a little before it
    task automatic send_update(input pc_t pc, input logic taken, input pc_t target,
                               input pc_t restart_pc);
        step_cycle();
        bp_update.valid = 1'b1;
        bp_update.pc = pc;
        bp_update.taken = taken;
        bp_update.target = target;
        ex_redirect.valid = 1'b1;
        ex_redirect.pc = restart_pc;
        train_model(pc, taken, target);
        exp_pc = restart_pc;
    endtask

    // transfer happens at the next rising edge, inputs are steady mid cycle
    always @(negedge clk) begin
        if (i_dut.i_fetch_queue.i_fetch_chk.err_cnt != 0) begin
            stop_on_failure("an assertion on the fetch queue failed");
        end
        if (arst_n && fetch_valid && fetch_ready) begin
            check_value("pc", exp_pc, fetch_req.pc);
            check_value("pred_taken", pc_t'(predict_taken(exp_pc)), pc_t'(fetch_req.pred_taken));
            exp_pc = next_pc(exp_pc);
            accept_cnt++;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_on_failure("watchdog expired before the tests finished");
    end

    initial begin
        seed = 4440;
        arst_n = 1'b0;
        ex_redirect = '0;
        id_redirect = '0;
        bp_update = '0;
        stall = 1'b0;
        fetch_ready = 1'b0;
        rand_ready = 1'b0;
        rand_stall = 1'b0;
        ready_level = 1'b1;
        accept_cnt = 0;
        model_valid = '0;
        exp_pc = START_PC;
        cur_test = "sequential";
        repeat (RESET_CYC) @(posedge clk);
        #1;
        arst_n = 1'b1;
        fetch_ready = 1'b1;

        wait_accepts(12, SEQ_CYC);

        cur_test = "back-pressure";
        rand_ready = 1'b1;
        rand_stall = 1'b1;
        wait_accepts(80, BP_CYC);

        // fill the queue first so stale entries are there to be flushed
        cur_test = "ex redirect";
        rand_ready = 1'b0;
        rand_stall = 1'b0;
        ready_level = 1'b0;
        repeat (8) step_cycle();
        send_redirect(1'b1, 32'h8000_2000, 1'b0, '0);
        ready_level = 1'b1;
        wait_accepts(10, EX_CYC);

        cur_test = "redirect priority";
        rand_ready = 1'b1;
        send_redirect(1'b0, '0, 1'b1, 32'h8000_3000);
        wait_accepts(8, PRI_CYC / 2);
        send_redirect(1'b1, 32'h8000_4000, 1'b1, 32'h8000_5000);
        wait_accepts(8, PRI_CYC / 2);

        // counter walks up and down, saturating at both ends
        cur_test = "prediction";
        rand_stall = 1'b1;
        for (int i = 0; i < PRED_STEPS; i++) begin
            send_update(BRANCH_PC, outcome_seq[i], TARGET_PC + pc_t'(i * 16), BRANCH_PC - 32'd8);
            wait_accepts(6, PRED_CYC / PRED_STEPS);
        end

        if (i_dut.i_fetch_queue.i_fetch_chk.err_cnt == 0) begin
            $display("All tests passed");
            $finish;
        end else begin
            stop_on_failure("an assertion on the fetch queue failed");
        end
    end

endmodule

`default_nettype wire

//--- project.f
rtl/fetch_pkg.sv
rtl/pc_gen.sv
rtl/branch_predictor.sv
rtl/fetch_queue.sv
rtl/fetch_top.sv
verification/fetch_chk.sv
verification/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  # synthesizable front end, package first
  - files:
      - rtl/fetch_pkg.sv
      - rtl/pc_gen.sv
      - rtl/branch_predictor.sv
      - rtl/fetch_queue.sv
      - rtl/fetch_top.sv

  # simulation only
  - target: test
    files:
      - verification/fetch_chk.sv
      - verification/fetch_tb.sv
